/* mips_alu.sv */
// arithmetic, logic, shift and compare unit
`timescale 1ns/1ps
`default_nettype none

module mips_alu (
   input  wire mips_ctrl_pkg::ctrl_t ctrl,
   input  wire mips_isa_pkg::word_t  rs_data,
   input  wire mips_isa_pkg::word_t  rt_data,
   output mips_isa_pkg::word_t       alu_out
);
   import mips_isa_pkg::*;
   import mips_ctrl_pkg::*;

   word_t op_a;
   word_t op_b;

   // variable shifts take rt as the value and rs as the amount
   assign op_a = ctrl.shift_var ? rt_data : rs_data;
   assign op_b = ctrl.shift_var ? rs_data :
                 (ctrl.alu_src_imm ? ctrl.imm : rt_data);

   always_comb begin
      case (ctrl.alu_op)
         ALU_ADDU: alu_out = op_a + op_b;
         ALU_SUBU: alu_out = op_a - op_b;
         ALU_AND:  alu_out = op_a & op_b;
         ALU_OR:   alu_out = op_a | op_b;
         ALU_XOR:  alu_out = op_a ^ op_b;
         ALU_NOR:  alu_out = ~(op_a | op_b);
         // signed compare, also used by slti
         ALU_SLT:  alu_out = {31'b0, ($signed(op_a) < $signed(op_b))};
         // fixed shifts move rt by the shamt field
         ALU_SLL:  alu_out = op_b << ctrl.shamt;
         ALU_SRL:  alu_out = op_b >> ctrl.shamt;
         ALU_SRA:  alu_out = $signed(op_b) >>> ctrl.shamt;
         // only the low five bits of rs count
         ALU_SLLV: alu_out = op_a << op_b[SHAMT_W-1:0];
         ALU_SRLV: alu_out = op_a >> op_b[SHAMT_W-1:0];
         ALU_SRAV: alu_out = $signed(op_a) >>> op_b[SHAMT_W-1:0];
         default:  alu_out = op_a + op_b;
      endcase
   end

endmodule

`default_nettype wire

/* mips_core.sv */
// single-cycle core top, fetch, decode, register file, alu and memory stage
`timescale 1ns/1ps
`default_nettype none

module mips_core (
   input  wire                           clk,
   input  wire                           rst_b,
   output mips_isa_pkg::word_addr_t      inst_addr,
   input  wire mips_isa_pkg::word_t      inst,
   input  wire                           inst_excpt,
   output mips_ctrl_pkg::dmem_req_t      dmem,
   input  wire mips_isa_pkg::word_t      mem_rdata,
   output logic                          halted
);
   import mips_isa_pkg::*;
   import mips_ctrl_pkg::*;

   word_t pc;
   ctrl_t ctrl;
   word_t rs_data;
   word_t rt_data;
   word_t v0_data;
   word_t alu_out;
   word_t wr_data;
   // a faulting fetch writes nothing, nor does a halted core
   logic  wr_block;

   // instruction memory is word addressed
   assign inst_addr = pc[WORD_W-1:2];

   assign wr_block = halted || inst_excpt;

   mips_fetch i_fetch (
      .clk        (clk),
      .rst_b      (rst_b),
      .ctrl       (ctrl),
      .rs_data    (rs_data),
      .rt_data    (rt_data),
      .v0_data    (v0_data),
      .inst_excpt (inst_excpt),
      .pc         (pc),
      .halted     (halted)
   );

   mips_decode i_decode (
      .inst (inst),
      .ctrl (ctrl)
   );

   // read indices come straight from the rs and rt fields
   mips_regfile i_regfile (
      .clk     (clk),
      .rst_b   (rst_b),
      .rs_idx  (inst[25:21]),
      .rt_idx  (inst[20:16]),
      .we      (ctrl.reg_write),
      .wr_idx  (ctrl.wr_idx),
      .wr_data (wr_data),
      .halted  (wr_block),
      .rs_data (rs_data),
      .rt_data (rt_data),
      .v0_data (v0_data)
   );

   mips_alu i_alu (
      .ctrl    (ctrl),
      .rs_data (rs_data),
      .rt_data (rt_data),
      .alu_out (alu_out)
   );

   mips_mem_stage i_mem_stage (
      .ctrl      (ctrl),
      .alu_out   (alu_out),
      .rt_data   (rt_data),
      .mem_rdata (mem_rdata),
      .halted    (wr_block),
      .dmem      (dmem),
      .wr_data   (wr_data)
   );

endmodule

`default_nettype wire

/* mips_core_chk.sv */
// concurrent assertions on reset state, fetch order and halt behavior of the core
`timescale 1ns/1ps
`default_nettype none

module mips_core_chk (
   input wire                            clk,
   input wire                            rst_b,
   input wire mips_isa_pkg::word_addr_t  inst_addr,
   input wire                            inst_excpt,
   input wire mips_ctrl_pkg::dmem_req_t  dmem,
   input wire                            halted,
   input wire mips_ctrl_pkg::ctrl_t      ctrl,
   input wire mips_isa_pkg::word_t       v0_data
);
   import mips_isa_pkg::*;
   import mips_ctrl_pkg::*;

   logic straight;

   // no flow change and nothing that could stop the core
   assign straight = !halted && !inst_excpt && !ctrl.reserved && !ctrl.syscall &&
                     !ctrl.beq && !ctrl.bne && !ctrl.jump && !ctrl.jump_reg;

   // first edge out of reset sees the text start and a quiet core
   reset_state: assert property (@(posedge clk)
      $rose(rst_b) |-> (inst_addr == TEXT_START[WORD_W-1:2]) && !halted && (dmem.we == '0))
      else $error("core not in reset state after reset release");

   fetch_order: assert property (@(posedge clk) disable iff (!rst_b)
      straight |=> (inst_addr == $past(inst_addr) + 1'b1))
      else $error("straight-line fetch did not advance by one word");

   exit_halts: assert property (@(posedge clk) disable iff (!rst_b)
      (!halted && ctrl.syscall && (v0_data == SYSCALL_EXIT)) |=> halted)
      else $error("exit syscall did not halt the core");

   fault_halts: assert property (@(posedge clk) disable iff (!rst_b)
      (!halted && (ctrl.reserved || inst_excpt)) |=> halted)
      else $error("reserved op or fetch fault did not halt the core");

   // once halted the pc freezes and memory is left alone
   halt_holds: assert property (@(posedge clk) disable iff (!rst_b)
      halted |=> halted && $stable(inst_addr))
      else $error("pc moved or halt dropped while halted");

   halt_no_write: assert property (@(posedge clk) disable iff (!rst_b)
      halted |-> (dmem.we == '0))
      else $error("write enable raised while halted");

endmodule

bind mips_core mips_core_chk i_chk (
   .clk        (clk),
   .rst_b      (rst_b),
   .inst_addr  (inst_addr),
   .inst_excpt (inst_excpt),
   .dmem       (dmem),
   .halted     (halted),
   .ctrl       (ctrl),
   .v0_data    (v0_data)
);

`default_nettype wire

/* mips_ctrl_pkg.sv */
// core-internal alu and load enums, store sizes, control bundle, data-memory request
`default_nettype none

package mips_ctrl_pkg;

   // alu operations, one per kept computation
   typedef enum logic [3:0] {
      ALU_ADDU,
      ALU_SUBU,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_NOR,
      ALU_SLT,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_SLLV,
      ALU_SRLV,
      ALU_SRAV
   } alu_op_t;

   // write-back source for loads and lui
   typedef enum logic [2:0] {
      LD_NONE,
      LD_LUI,
      LD_LB,
      LD_LH,
      LD_LW,
      LD_LBU,
      LD_LHU
   } load_kind_t;

   typedef logic [1:0] store_size_t;
   localparam store_size_t ST_NONE = 2'd0;
   localparam store_size_t ST_BYTE = 2'd1;
   localparam store_size_t ST_HALF = 2'd2;
   localparam store_size_t ST_WORD = 2'd3;

   // one enable per byte lane of a data word
   typedef logic [3:0] byte_en_t;

   typedef struct packed {
      logic                                    reg_write;
      mips_isa_pkg::reg_idx_t                  wr_idx;
      alu_op_t                                 alu_op;
      // second alu operand taken from the immediate
      logic                                    alu_src_imm;
      // sllv/srlv/srav shift rt by rs, so the operands trade places
      logic                                    shift_var;
      load_kind_t                              load_kind;
      store_size_t                             store_size;
      logic                                    beq;
      logic                                    bne;
      logic                                    jump;
      logic                                    jump_reg;
      logic                                    syscall;
      logic                                    reserved;
      mips_isa_pkg::word_t                     imm;
      logic [mips_isa_pkg::TARGET_W-1:0]       target;
      logic [mips_isa_pkg::SHAMT_W-1:0]        shamt;
   } ctrl_t;

   typedef struct packed {
      mips_isa_pkg::word_addr_t addr;
      mips_isa_pkg::word_t      wdata;
      byte_en_t                 we;
   } dmem_req_t;

endpackage

`default_nettype wire

/* mips_decode.sv */
// field extraction, immediate extension and control bundle generation
`timescale 1ns/1ps
`default_nettype none

module mips_decode (
   input  wire mips_isa_pkg::word_t inst,
   output mips_ctrl_pkg::ctrl_t     ctrl
);
   import mips_isa_pkg::*;
   import mips_ctrl_pkg::*;

   opcode_t                opcode;
   funct_t                 funct;
   reg_idx_t               rt;
   reg_idx_t               rd;
   logic [SHAMT_W-1:0]     shamt;
   logic [IMM_W-1:0]       imm;
   logic [TARGET_W-1:0]    target;
   word_t                  imm_sext;
   word_t                  imm_zext;

   // r-type and i-type share the upper fields
   assign opcode = inst[31:26];
   assign rt     = inst[20:16];
   assign rd     = inst[15:11];
   assign shamt  = inst[10:6];
   assign funct  = inst[5:0];
   assign imm    = inst[15:0];
   assign target = inst[25:0];

   assign imm_sext = {{(WORD_W-IMM_W){imm[IMM_W-1]}}, imm};
   assign imm_zext = {{(WORD_W-IMM_W){1'b0}}, imm};

   always_comb begin
      // default is a no-op that writes nothing
      ctrl            = '0;
      ctrl.alu_op     = ALU_ADDU;
      ctrl.load_kind  = LD_NONE;
      ctrl.store_size = ST_NONE;
      ctrl.wr_idx     = rt;
      ctrl.imm        = imm_sext;
      ctrl.target     = target;
      ctrl.shamt      = shamt;

      case (opcode)
         OP_SPECIAL: begin
            // r-type writes rd
            ctrl.wr_idx    = rd;
            ctrl.reg_write = 1'b1;
            case (funct)
               FN_ADDU: ctrl.alu_op = ALU_ADDU;
               FN_SUBU: ctrl.alu_op = ALU_SUBU;
               FN_AND:  ctrl.alu_op = ALU_AND;
               FN_OR:   ctrl.alu_op = ALU_OR;
               FN_XOR:  ctrl.alu_op = ALU_XOR;
               FN_NOR:  ctrl.alu_op = ALU_NOR;
               FN_SLT:  ctrl.alu_op = ALU_SLT;
               FN_SLL:  ctrl.alu_op = ALU_SLL;
               FN_SRL:  ctrl.alu_op = ALU_SRL;
               FN_SRA:  ctrl.alu_op = ALU_SRA;
               FN_SLLV: begin
                  ctrl.alu_op    = ALU_SLLV;
                  ctrl.shift_var = 1'b1;
               end
               FN_SRLV: begin
                  ctrl.alu_op    = ALU_SRLV;
                  ctrl.shift_var = 1'b1;
               end
               FN_SRAV: begin
                  ctrl.alu_op    = ALU_SRAV;
                  ctrl.shift_var = 1'b1;
               end
               FN_JR: begin
                  ctrl.reg_write = 1'b0;
                  ctrl.jump_reg  = 1'b1;
               end
               FN_SYSCALL: begin
                  ctrl.reg_write = 1'b0;
                  ctrl.syscall   = 1'b1;
               end
               default: begin
                  ctrl.reg_write = 1'b0;
                  ctrl.reserved  = 1'b1;
               end
            endcase
         end
         OP_ADDIU, OP_SLTI: begin
            ctrl.reg_write   = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            ctrl.alu_op      = (opcode == OP_SLTI) ? ALU_SLT : ALU_ADDU;
         end
         OP_ANDI, OP_ORI, OP_XORI: begin
            // logical immediates are zero-extended
            ctrl.reg_write   = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            ctrl.imm         = imm_zext;
            case (opcode)
               OP_ANDI: ctrl.alu_op = ALU_AND;
               OP_ORI:  ctrl.alu_op = ALU_OR;
               default: ctrl.alu_op = ALU_XOR;
            endcase
         end
         OP_LUI: begin
            ctrl.reg_write = 1'b1;
            ctrl.imm       = imm_zext;
            ctrl.load_kind = LD_LUI;
         end
         OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
            // address is rs plus the signed offset
            ctrl.reg_write   = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            case (opcode)
               OP_LB:   ctrl.load_kind = LD_LB;
               OP_LH:   ctrl.load_kind = LD_LH;
               OP_LBU:  ctrl.load_kind = LD_LBU;
               OP_LHU:  ctrl.load_kind = LD_LHU;
               default: ctrl.load_kind = LD_LW;
            endcase
         end
         OP_SB: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.store_size  = ST_BYTE;
         end
         OP_SH: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.store_size  = ST_HALF;
         end
         OP_SW: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.store_size  = ST_WORD;
         end
         OP_BEQ: ctrl.beq = 1'b1;
         OP_BNE: ctrl.bne = 1'b1;
         OP_J:   ctrl.jump = 1'b1;
         default: ctrl.reserved = 1'b1;
      endcase
   end

endmodule

`default_nettype wire

/* mips_fetch.sv */
// program counter, next-pc selection and the halt flag
`timescale 1ns/1ps
`default_nettype none

module mips_fetch (
   input  wire                   clk,
   input  wire                   rst_b,
   input  wire mips_ctrl_pkg::ctrl_t ctrl,
   input  wire mips_isa_pkg::word_t  rs_data,
   input  wire mips_isa_pkg::word_t  rt_data,
   input  wire mips_isa_pkg::word_t  v0_data,
   input  wire                   inst_excpt,
   output mips_isa_pkg::word_t   pc,
   output logic                  halted
);
   import mips_isa_pkg::*;
   import mips_ctrl_pkg::*;

   word_t pc_plus4;
   word_t br_target;
   word_t jmp_target;
   word_t next_pc;
   logic  br_taken;
   logic  halt_now;

   assign pc_plus4 = pc + 32'd4;
   // branch offset counts words from the delay-free next pc
   assign br_target = pc_plus4 + {ctrl.imm[WORD_W-3:0], 2'b00};
   // j keeps the top four bits of the sequential pc
   assign jmp_target = {pc_plus4[WORD_W-1:WORD_W-4], ctrl.target, 2'b00};

   assign br_taken = (ctrl.beq && (rs_data == rt_data)) ||
                     (ctrl.bne && (rs_data != rt_data));

   always_comb begin
      if (ctrl.jump_reg) begin
         next_pc = rs_data;
      end else if (ctrl.jump) begin
         next_pc = jmp_target;
      end else if (br_taken) begin
         next_pc = br_target;
      end else begin
         next_pc = pc_plus4;
      end
   end

   // reserved op, exit syscall or a faulting fetch all stop the core
   assign halt_now = ctrl.reserved ||
                     (ctrl.syscall && (v0_data == SYSCALL_EXIT)) ||
                     inst_excpt;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc     <= TEXT_START;
         halted <= 1'b0;
      end else if (!halted) begin
         if (halt_now) begin
            // pc stays on the halting instruction
            halted <= 1'b1;
         end else begin
            pc <= next_pc;
         end
      end
   end

endmodule

`default_nettype wire

/* mips_isa_pkg.sv */
// instruction-set widths, word types, opcode and function codes, reset pc
`default_nettype none

package mips_isa_pkg;

   // field widths of the instruction word
   localparam int WORD_W    = 32;
   localparam int OPCODE_W  = 6;
   localparam int FUNCT_W   = 6;
   localparam int REG_IDX_W = 5;
   localparam int SHAMT_W   = 5;
   localparam int IMM_W     = 16;
   localparam int TARGET_W  = 26;
   localparam int NUM_REGS  = 32;

   typedef logic [WORD_W-1:0]    word_t;
   // word address drops the two byte-offset bits
   typedef logic [WORD_W-3:0]    word_addr_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;
   typedef logic [OPCODE_W-1:0]  opcode_t;
   typedef logic [FUNCT_W-1:0]   funct_t;

   // primary opcodes
   localparam opcode_t OP_SPECIAL = 6'h00;
   localparam opcode_t OP_J       = 6'h02;
   localparam opcode_t OP_BEQ     = 6'h04;
   localparam opcode_t OP_BNE     = 6'h05;
   localparam opcode_t OP_ADDIU   = 6'h09;
   localparam opcode_t OP_SLTI    = 6'h0a;
   localparam opcode_t OP_ANDI    = 6'h0c;
   localparam opcode_t OP_ORI     = 6'h0d;
   localparam opcode_t OP_XORI    = 6'h0e;
   localparam opcode_t OP_LUI     = 6'h0f;
   localparam opcode_t OP_LB      = 6'h20;
   localparam opcode_t OP_LH      = 6'h21;
   localparam opcode_t OP_LW      = 6'h23;
   localparam opcode_t OP_LBU     = 6'h24;
   localparam opcode_t OP_LHU     = 6'h25;
   localparam opcode_t OP_SB      = 6'h28;
   localparam opcode_t OP_SH      = 6'h29;
   localparam opcode_t OP_SW      = 6'h2b;

   // function codes under OP_SPECIAL
   localparam funct_t FN_SLL     = 6'h00;
   localparam funct_t FN_SRL     = 6'h02;
   localparam funct_t FN_SRA     = 6'h03;
   localparam funct_t FN_SLLV    = 6'h04;
   localparam funct_t FN_SRLV    = 6'h06;
   localparam funct_t FN_SRAV    = 6'h07;
   localparam funct_t FN_JR      = 6'h08;
   localparam funct_t FN_SYSCALL = 6'h0c;
   localparam funct_t FN_ADDU    = 6'h21;
   localparam funct_t FN_SUBU    = 6'h23;
   localparam funct_t FN_AND     = 6'h24;
   localparam funct_t FN_OR      = 6'h25;
   localparam funct_t FN_XOR     = 6'h26;
   localparam funct_t FN_NOR     = 6'h27;
   localparam funct_t FN_SLT     = 6'h2a;

   // start of the text segment, first fetch after reset
   localparam word_t    TEXT_START   = 32'h0040_0000;
   // syscall argument register and the exit service number
   localparam reg_idx_t REG_V0       = 5'd2;
   localparam word_t    SYSCALL_EXIT = 32'd10;

endpackage

`default_nettype wire

/* mips_mem_stage.sv */
// store lane enables and data placement, load extraction and write-back select
`timescale 1ns/1ps
`default_nettype none

module mips_mem_stage (
   input  wire mips_ctrl_pkg::ctrl_t ctrl,
   input  wire mips_isa_pkg::word_t  alu_out,
   input  wire mips_isa_pkg::word_t  rt_data,
   input  wire mips_isa_pkg::word_t  mem_rdata,
   input  wire                       halted,
   output mips_ctrl_pkg::dmem_req_t  dmem,
   output mips_isa_pkg::word_t       wr_data
);
   import mips_isa_pkg::*;
   import mips_ctrl_pkg::*;

   logic [1:0]  byte_off;
   logic [7:0]  ld_byte;
   logic [15:0] ld_half;

   assign byte_off = alu_out[1:0];

   // byte lanes are little-endian, offset 0 is bits 7:0
   assign ld_byte = mem_rdata[{byte_off, 3'b000} +: 8];
   assign ld_half = mem_rdata[{byte_off[1], 4'b0000} +: 16];

   always_comb begin
      dmem.addr = alu_out[WORD_W-1:2];
      case (ctrl.store_size)
         ST_BYTE: begin
            dmem.wdata = {4{rt_data[7:0]}};
            dmem.we    = byte_en_t'(4'b0001 << byte_off);
         end
         ST_HALF: begin
            dmem.wdata = {2{rt_data[15:0]}};
            dmem.we    = byte_off[1] ? 4'b1100 : 4'b0011;
         end
         ST_WORD: begin
            dmem.wdata = rt_data;
            dmem.we    = 4'b1111;
         end
         default: begin
            dmem.wdata = rt_data;
            dmem.we    = 4'b0000;
         end
      endcase
      // a halted core leaves memory alone
      if (halted) begin
         dmem.we = 4'b0000;
      end
   end

   always_comb begin
      case (ctrl.load_kind)
         LD_LUI:  wr_data = {ctrl.imm[IMM_W-1:0], 16'h0000};
         LD_LB:   wr_data = {{24{ld_byte[7]}}, ld_byte};
         LD_LBU:  wr_data = {24'h000000, ld_byte};
         LD_LH:   wr_data = {{16{ld_half[15]}}, ld_half};
         LD_LHU:  wr_data = {16'h0000, ld_half};
         LD_LW:   wr_data = mem_rdata;
         default: wr_data = alu_out;
      endcase
   end

endmodule

`default_nettype wire

/* mips_regfile.sv */
// general register file, two read ports, v0 read-out and one write port
`timescale 1ns/1ps
`default_nettype none

module mips_regfile (
   input  wire                           clk,
   input  wire                           rst_b,
   input  wire mips_isa_pkg::reg_idx_t   rs_idx,
   input  wire mips_isa_pkg::reg_idx_t   rt_idx,
   input  wire                           we,
   input  wire mips_isa_pkg::reg_idx_t   wr_idx,
   input  wire mips_isa_pkg::word_t      wr_data,
   input  wire                           halted,
   output mips_isa_pkg::word_t           rs_data,
   output mips_isa_pkg::word_t           rt_data,
   output mips_isa_pkg::word_t           v0_data
);
   import mips_isa_pkg::*;

   word_t regs [NUM_REGS];

   // $zero is never written, so it keeps its reset value
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (we && !halted && (wr_idx != '0)) begin
         regs[wr_idx] <= wr_data;
      end
   end

   // asynchronous reads
   assign rs_data = regs[rs_idx];
   assign rt_data = regs[rt_idx];
   // syscall service number for the halt check
   assign v0_data = regs[REG_V0];

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
   -f verilog.f \
   --top-module tb_mips_core \
   -o sim_tb_mips_core

./obj_dir/sim_tb_mips_core > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
   exit 0
fi
exit 1

/* tb_mips_core.sv */
// testbench with clock, reset, program builder, memory models and store checks
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;
   import mips_isa_pkg::*;
   import mips_ctrl_pkg::*;

   localparam int TIMEOUT = 2000;
   localparam int BASE_W  = TEXT_START >> 2;
   localparam int ST_BASE = 'h80;

   logic       clk;
   logic       rst_b;
   word_addr_t inst_addr;
   word_t      inst;
   logic       inst_excpt;
   dmem_req_t  dmem;
   dmem_req_t  req_q;
   word_t      mem_rdata;
   logic       halted;

   word_t      prog[$];
   dmem_req_t  exp_q[$];
   word_t      dmem_arr[256];
   // memory contents as the program should leave them
   word_t      smem[256];
   word_t      regm[32];
   int         excpt_idx;
   int         st_addr;
   int         seed;

   mips_core i_mips_core (
      .clk        (clk),
      .rst_b      (rst_b),
      .inst_addr  (inst_addr),
      .inst       (inst),
      .inst_excpt (inst_excpt),
      .dmem       (dmem),
      .mem_rdata  (mem_rdata),
      .halted     (halted)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic report(string msg);
      $display("ERROR at %0t ns: %s", $time, msg);
      $display("SIMULATION FAILED");
      $fatal(1);
   endtask

   function automatic word_t enc_r(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                   logic [4:0] sh, funct_t fn);
      return {OP_SPECIAL, rs, rt, rd, sh, fn};
   endfunction

   function automatic word_t enc_i(opcode_t op, logic [4:0] rs, logic [4:0] rt,
                                   logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // r-type results from the instruction definitions
   function automatic word_t r_ref(funct_t fn, word_t a, word_t b, logic [4:0] sh);
      case (fn)
         FN_ADDU: return a + b;
         FN_SUBU: return a - b;
         FN_AND:  return a & b;
         FN_OR:   return a | b;
         FN_XOR:  return a ^ b;
         FN_NOR:  return ~(a | b);
         FN_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         FN_SLL:  return b << sh;
         FN_SRL:  return b >> sh;
         FN_SRA:  return $signed(b) >>> sh;
         FN_SLLV: return b << a[4:0];
         FN_SRLV: return b >> a[4:0];
         default: return $signed(b) >>> a[4:0];
      endcase
   endfunction

   function automatic word_t i_ref(opcode_t op, word_t a, logic [15:0] imm);
      word_t se;
      se = {{16{imm[15]}}, imm};
      case (op)
         OP_ADDIU: return a + se;
         OP_SLTI:  return ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
         OP_ANDI:  return a & {16'h0, imm};
         OP_ORI:   return a | {16'h0, imm};
         OP_XORI:  return a ^ {16'h0, imm};
         default:  return {imm, 16'h0};
      endcase
   endfunction

   function automatic word_t ld_ref(opcode_t op, word_t w, int off);
      logic [7:0]  b;
      logic [15:0] h;
      b = w[8*off +: 8];
      h = w[8*(off & 2) +: 16];
      case (op)
         OP_LB:   return {{24{b[7]}}, b};
         OP_LBU:  return {24'h0, b};
         OP_LH:   return {{16{h[15]}}, h};
         OP_LHU:  return {16'h0, h};
         default: return w;
      endcase
   endfunction

   // queue a store the core must make, and fold it into the memory image
   task automatic exp_store(int addr, logic [3:0] we, word_t data);
      dmem_req_t r;
      r.addr  = word_addr_t'(addr);
      r.wdata = data;
      r.we    = we;
      exp_q.push_back(r);
      for (int l = 0; l < 4; l++) begin
         if (we[l]) begin
            smem[addr][8*l +: 8] = data[8*l +: 8];
         end
      end
   endtask

   task automatic li(logic [4:0] r, word_t val);
      prog.push_back(enc_i(OP_LUI, 5'd0, r, val[31:16]));
      prog.push_back(enc_i(OP_ORI, r, r, val[15:0]));
      regm[r] = val;
   endtask

   task automatic store_result(logic [4:0] r);
      prog.push_back(enc_i(OP_SW, 5'd0, r, 16'(st_addr * 4)));
      exp_store(st_addr, 4'hf, regm[r]);
      st_addr++;
   endtask

   // r13 holds the poison value, word 0xf0 is never expected
   task automatic poison();
      prog.push_back(enc_i(OP_SW, 5'd0, 5'd13, 16'h03c0));
   endtask

   task automatic start_run();
      rst_b = 1'b0;
      prog.delete();
      exp_q.delete();
      excpt_idx = -1;
      st_addr   = ST_BASE;
      for (int i = 0; i < 32; i++) begin
         regm[i] = '0;
      end
   endtask

   task automatic release_and_wait();
      int n;
      repeat (2) @(negedge clk);
      rst_b = 1'b1;
      n = 0;
      while (!halted && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (!halted) begin
         $display("timeout: the core never halted at %0t ns", $time);
         $display("SIMULATION FAILED");
         $fatal(1);
      end
      repeat (4) @(negedge clk);
      assert (exp_q.size() == 0) else report("expected stores never happened");
   endtask

   // instruction fetch and load data, driven on the falling edge
   always @(negedge clk) begin
      int idx;
      idx = int'(inst_addr) - BASE_W;
      inst = (idx >= 0 && idx < prog.size()) ? prog[idx] : 32'h0;
      inst_excpt = (idx == excpt_idx);
      #1;
      mem_rdata = dmem_arr[dmem.addr[7:0]];
      req_q = dmem;
   end

   // store check and byte-lane write at the rising edge
   always @(posedge clk) begin
      if (rst_b && req_q.we != 4'h0) begin
         assert (exp_q.size() > 0) else report("unexpected store");
         assert (req_q == exp_q[0]) else
            report($sformatf("store addr %h data %h we %b, expected %h %h %b",
                   req_q.addr, req_q.wdata, req_q.we,
                   exp_q[0].addr, exp_q[0].wdata, exp_q[0].we));
         void'(exp_q.pop_front());
         for (int l = 0; l < 4; l++) begin
            if (req_q.we[l]) begin
               dmem_arr[req_q.addr[7:0]][8*l +: 8] = req_q.wdata[8*l +: 8];
            end
         end
      end
   end

   initial begin
      funct_t      r_ops[13];
      opcode_t     i_ops[6];
      opcode_t     l_ops[5];
      logic [4:0]  sh;
      logic [15:0] imm;
      int          t;
      r_ops = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT,
                FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};
      i_ops = '{OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_LUI};
      l_ops = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
      seed = $urandom(32'ha558);
      rst_b = 1'b0;
      inst = '0;
      inst_excpt = 1'b0;
      mem_rdata = '0;
      req_q = '0;
      for (int i = 0; i < 256; i++) begin
         dmem_arr[i] = $urandom;
         smem[i] = dmem_arr[i];
      end

      // run 1 covers alu, loads, stores and flow, ends on syscall
      start_run();
      li(8, $urandom);
      li(9, $urandom);
      if (regm[9] == regm[8]) begin
         li(9, regm[8] ^ 32'h1);
      end
      li(10, $urandom);
      li(13, 32'hbad0_0bad);
      foreach (r_ops[k]) begin
         sh = 5'($urandom);
         prog.push_back(enc_r(5'd10, 5'd9, 5'd11, sh, r_ops[k]));
         regm[11] = (k < 10) ? r_ref(r_ops[k], regm[8], regm[9], sh) :
                               r_ref(r_ops[k], regm[10], regm[9], sh);
         if (k < 7) begin
            prog[prog.size()-1] = enc_r(5'd8, 5'd9, 5'd11, 5'd0, r_ops[k]);
            regm[11] = r_ref(r_ops[k], regm[8], regm[9], 5'd0);
         end
         store_result(11);
      end
      foreach (i_ops[k]) begin
         imm = 16'($urandom);
         prog.push_back(enc_i(i_ops[k], 5'd8, 5'd12, imm));
         regm[12] = i_ref(i_ops[k], regm[8], imm);
         store_result(12);
      end
      foreach (l_ops[k]) begin
         for (int off = 0; off < 4; off++) begin
            if ((l_ops[k] == OP_LH || l_ops[k] == OP_LHU) && off[0]) continue;
            if (l_ops[k] == OP_LW && off != 0) continue;
            prog.push_back(enc_i(l_ops[k], 5'd0, 5'd11, 16'('h100 + off)));
            regm[11] = ld_ref(l_ops[k], smem['h40], off);
            store_result(11);
         end
      end
      for (int k = 0; k < 4; k++) begin
         prog.push_back(enc_i(OP_SB, 5'd0, 5'(8 + k % 3), 16'('h140 + k)));
         exp_store('h50, 4'(1 << k), {4{regm[8 + k % 3][7:0]}});
      end
      prog.push_back(enc_i(OP_SH, 5'd0, 5'd9, 16'h0144));
      exp_store('h51, 4'b0011, {2{regm[9][15:0]}});
      prog.push_back(enc_i(OP_SH, 5'd0, 5'd10, 16'h0146));
      exp_store('h51, 4'b1100, {2{regm[10][15:0]}});
      for (int k = 0; k < 2; k++) begin
         prog.push_back(enc_i(OP_LW, 5'd0, 5'd11, 16'('h140 + 4 * k)));
         regm[11] = smem['h50 + k];
         store_result(11);
      end
      prog.push_back(enc_i(OP_BEQ, 5'd8, 5'd8, 16'd1));
      poison();
      store_result(8);
      prog.push_back(enc_i(OP_BNE, 5'd8, 5'd9, 16'd1));
      poison();
      store_result(9);
      t = prog.size() + 2;
      prog.push_back({OP_J, 26'(BASE_W + t)});
      poison();
      store_result(10);
      t = prog.size() + 4;
      li(14, TEXT_START + 4 * t);
      prog.push_back(enc_r(5'd14, 5'd0, 5'd0, 5'd0, FN_JR));
      poison();
      store_result(8);
      // not taken, falls through to both stores
      prog.push_back(enc_i(OP_BEQ, 5'd8, 5'd9, 16'd1));
      store_result(9);
      store_result(10);
      prog.push_back(enc_i(OP_ADDIU, 5'd0, REG_V0, 16'd10));
      prog.push_back(enc_r(5'd0, 5'd0, 5'd0, 5'd0, FN_SYSCALL));
      poison();
      release_and_wait();

      // run 2 ends on a reserved opcode
      start_run();
      li(8, $urandom);
      li(13, 32'hbad0_0bad);
      store_result(8);
      prog.push_back(32'hfc00_0000);
      poison();
      release_and_wait();

      // run 3 ends on a store whose fetch faults, so it must not write
      start_run();
      li(9, $urandom);
      li(13, 32'hbad0_0bad);
      store_result(9);
      excpt_idx = prog.size();
      poison();
      poison();
      release_and_wait();

      if (exp_q.size() == 0) begin
         $display("SIMULATION PASSED");
         $finish;
      end else begin
         $display("SIMULATION FAILED");
         $fatal(1);
      end
   end

endmodule

`default_nettype wire

/* verilog.f */
mips_isa_pkg.sv
mips_ctrl_pkg.sv
mips_fetch.sv
mips_decode.sv
mips_regfile.sv
mips_alu.sv
mips_mem_stage.sv
mips_core.sv
mips_core_chk.sv
tb_mips_core.sv
